// ==== build.f ====
+incdir+source
source/hash_regs_pkg.sv
source/word_push_if.sv
source/sys_regfile.sv
source/block_fifo.sv
source/engine_link.sv
source/hash_regs_top.sv
bench/hash_regs_chk.sv
bench/hash_regs_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the hash register block testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module hash_regs_tb -o Vhash_regs_tb

out=$(./obj_dir/Vhash_regs_tb)
echo "$out"

# pass only when the testbench printed its pass line
grep -q "^STATUS: PASS$" <<< "$out"

// ==== bench/hash_regs_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hash_regs_config.svh"

module hash_regs_tb;
  import hash_regs_pkg::*;

  localparam int N_TESTS         = 7;
  localparam int WATCHDOG_CYCLES = N_TESTS * 200 + 400;   // 200 per test block plus margin
  localparam int ACK_TIMEOUT     = 20;
  localparam int ENGINE_TIMEOUT  = 200;

  logic      clk_100mhz;
  logic      rstn_i;
  bus_word_t sys_addr_i;
  bus_word_t sys_wdata_i;
  logic [3:0] sys_sel_i;
  logic      sys_wen_i;
  logic      sys_ren_i;
  bus_word_t sys_rdata_o;
  logic      sys_err_o;
  logic      sys_ack_o;
  logic      blk_req_o;
  block_t    blk_data_o;
  logic      blk_ack_i;
  logic      hash_valid_i;
  digest_t   hash_i;
  logic      active_o;

  int        mismatch_cnt;
  int        fail_cnt;
  int        assert_cnt;        // failures of the bound checker
  int        blocks_seen;       // blocks acked by the engine model
  int        hashes_sent;
  block_t    last_block;
  block_t    eng_block;
  int        eng_delay;
  logic      eng_hold;          // engine holds off its ack while set
  bus_word_t rd_q;              // last read data
  bus_word_t push_word;
  block_t    exp_block;
  digest_t   exp_hash;

  hash_regs_top u_hash_regs_top (
    .clk_100mhz   (clk_100mhz),
    .rstn_i       (rstn_i),
    .sys_addr_i   (sys_addr_i),
    .sys_wdata_i  (sys_wdata_i),
    .sys_sel_i    (sys_sel_i),
    .sys_wen_i    (sys_wen_i),
    .sys_ren_i    (sys_ren_i),
    .sys_rdata_o  (sys_rdata_o),
    .sys_err_o    (sys_err_o),
    .sys_ack_o    (sys_ack_o),
    .blk_req_o    (blk_req_o),
    .blk_data_o   (blk_data_o),
    .blk_ack_i    (blk_ack_i),
    .hash_valid_i (hash_valid_i),
    .hash_i       (hash_i),
    .active_o     (active_o)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;   // 100 MHz
  end

  // --------------------------------------------------------------------------
  // bus access, one cycle request then wait for ack
  // --------------------------------------------------------------------------
  task automatic bus_access(input logic wr, input logic [19:0] addr, input bus_word_t wdata);
    int waited;
    waited = 0;
    @(posedge clk_100mhz);
    sys_addr_i  <= {12'h000, addr};
    sys_wdata_i <= wdata;
    sys_sel_i   <= 4'hF;
    sys_wen_i   <= wr;
    sys_ren_i   <= !wr;
    @(posedge clk_100mhz);
    sys_wen_i   <= 1'b0;
    sys_ren_i   <= 1'b0;
    @(negedge clk_100mhz);                 // sample mid cycle
    while (!sys_ack_o && waited < ACK_TIMEOUT) begin
      waited++;
      @(negedge clk_100mhz);
    end
    if (!sys_ack_o) begin
      fail_cnt++;
      $display("[%0t] no bus ack for address %h", $time, addr);
    end
    assert (!sys_err_o) else begin
      fail_cnt++;
      $display("[%0t] sys_err_o high for address %h", $time, addr);
    end
    rd_q = sys_rdata_o;
  endtask

  task automatic check_read(input logic [19:0] addr, input bus_word_t exp, input string what);
    bus_access(1'b0, addr, '0);
    assert (rd_q == exp) else begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s read %h, expected %h", $time, what, rd_q, exp);
    end
  endtask

  task automatic wait_hashes(input int n);
    int waited;
    waited = 0;
    while (hashes_sent < n && waited < ENGINE_TIMEOUT) begin
      waited++;
      @(posedge clk_100mhz);
    end
    if (hashes_sent < n) begin
      fail_cnt++;
      $display("[%0t] engine never received the expected block", $time);
    end
  endtask

  // 512 bits folded onto 256 by xor of the two halves
  function automatic digest_t xor_fold(input block_t blk);
    return blk[255:0] ^ blk[511:256];
  endfunction

  // --------------------------------------------------------------------------
  // engine model
  // --------------------------------------------------------------------------
  initial begin
    forever begin
      @(posedge clk_100mhz);
      if (rstn_i && blk_req_o && !blk_ack_i) begin
        eng_block = blk_data_o;
        while (eng_hold) @(posedge clk_100mhz);   // back-pressure
        eng_delay = $urandom_range(6, 1);  // random ack latency
        repeat (eng_delay) @(posedge clk_100mhz);
        blk_ack_i <= 1'b1;
        do @(posedge clk_100mhz); while (blk_req_o);
        blk_ack_i <= 1'b0;                 // four-phase return to zero
        last_block = eng_block;
        blocks_seen++;
        repeat (2) @(posedge clk_100mhz);
        hash_i       <= xor_fold(eng_block);
        hash_valid_i <= 1'b1;
        repeat (3) @(posedge clk_100mhz);
        hash_valid_i <= 1'b0;
        hashes_sent++;
      end
    end
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_100mhz);
    $display("watchdog expired, the run did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(32'h16a4));
    rstn_i       = 1'b0;
    sys_addr_i   = '0;
    sys_wdata_i  = '0;
    sys_sel_i    = 4'h0;
    sys_wen_i    = 1'b0;
    sys_ren_i    = 1'b0;
    blk_ack_i    = 1'b0;
    hash_valid_i = 1'b0;
    hash_i       = '0;
    eng_hold     = 1'b0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    blocks_seen  = 0;
    hashes_sent  = 0;
    repeat (10) @(posedge clk_100mhz);
    rstn_i <= 1'b1;

    // reset values, link idle and fifo empty
    check_read(`HR_ADDR_CTRL, '0, "ctrl");
    check_read(`HR_ADDR_STATUS, '0, "status");
    check_read(`HR_ADDR_DATE, `HR_BUILD_DATE, "date");
    check_read(`HR_ADDR_SHA_CTRL, '0, "sha ctrl");
    check_read(`HR_ADDR_SHA_STATUS, bus_word_t'((1 << SS_IDLE) | (1 << SS_EMPTY)), "sha status");
    check_read(20'h00008, '0, "unmapped");
    check_read(`HR_ADDR_HASH_BASE, '0, "hash word 0");

    // enable
    bus_access(1'b1, `HR_ADDR_CTRL, 32'h1);
    check_read(`HR_ADDR_CTRL, 32'h1, "ctrl");
    check_read(`HR_ADDR_STATUS, bus_word_t'((1 << ST_ACTIVE) | (1 << ST_SHA_EN)), "status");
    assert (active_o) else begin
      fail_cnt++;
      $display("[%0t] active_o stayed low after enable", $time);
    end

    // stray half pair, then sha reset
    bus_access(1'b1, `HR_ADDR_SHA_PUSH, 32'hDEADBEEF);
    bus_access(1'b1, `HR_ADDR_SHA_CTRL, 32'h1);
    check_read(`HR_ADDR_SHA_CTRL, '0, "sha ctrl after reset");

    // sixteen words make one block, word i at bits 32i
    for (int i = 0; i < 16; i++) begin
      push_word = $urandom;
      exp_block[32*i +: 32] = push_word;
      bus_access(1'b1, `HR_ADDR_SHA_PUSH, push_word);
    end
    wait_hashes(1);
    assert (blocks_seen == 1 && last_block == exp_block) else begin
      mismatch_cnt++;
      $display("mismatch at %0t: %0d blocks, data %h", $time, blocks_seen, last_block);
    end
    check_read(`HR_ADDR_SHA_STATUS,
               bus_word_t'((1 << SS_IDLE) | (1 << SS_EMPTY) | (1 << SS_HASH_VALID)),
               "sha status after block");

    // captured digest
    exp_hash = xor_fold(exp_block);
    for (int k = 0; k < 8; k++) begin
      check_read(`HR_ADDR_HASH_BASE + 20'(4 * k), exp_hash[32*k +: 32], "hash word");
    end

    // stalled engine, a second block waits while the first is acked
    eng_hold = 1'b1;
    for (int i = 0; i < 32; i++) begin
      push_word = $urandom;
      exp_block[32*(i % 16) +: 32] = push_word;
      bus_access(1'b1, `HR_ADDR_SHA_PUSH, push_word);
    end
    eng_hold = 1'b0;
    wait_hashes(3);
    assert (blocks_seen == 3 && last_block == exp_block) else begin
      mismatch_cnt++;
      $display("mismatch at %0t: %0d blocks, data %h", $time, blocks_seen, last_block);
    end

    assert_cnt = u_hash_regs_top.u_hash_regs_chk.err_cnt;
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_cnt, fail_cnt, assert_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0 && assert_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/hash_regs_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module hash_regs_chk (
  input wire                           clk_100mhz,
  input wire                           rstn_i,
  input wire                           sys_wen_i,
  input wire                           sys_ren_i,
  input wire                           sys_ack_o,
  input wire                           blk_req_o,
  input wire hash_regs_pkg::block_t    blk_data_o,
  input wire                           blk_ack_i
);

  int err_cnt = 0;                     // failed assertions so far

  // --------------------------------------------------------------------------
  // system bus
  // --------------------------------------------------------------------------
  // every request is acked on the following edge
  ack_follows_req: assert property (
    @(posedge clk_100mhz) disable iff (!rstn_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o
  ) else begin
    err_cnt++;
    $error("bus request not acked one cycle later");
  end

  // --------------------------------------------------------------------------
  // engine four-phase handshake
  // --------------------------------------------------------------------------
  // block data frozen while the request stays high
  data_stable_in_req: assert property (
    @(posedge clk_100mhz) disable iff (!rstn_i)
    (blk_req_o && $past(blk_req_o)) |-> $stable(blk_data_o)
  ) else begin
    err_cnt++;
    $error("blk_data_o changed during an open request");
  end

  // no new request while the last ack is still up
  no_req_under_ack: assert property (
    @(posedge clk_100mhz) disable iff (!rstn_i)
    $rose(blk_req_o) |-> !$past(blk_ack_i)
  ) else begin
    err_cnt++;
    $error("blk_req_o rose while blk_ack_i was high");
  end

  // quiet after reset
  req_low_in_reset: assert property (
    @(posedge clk_100mhz)
    !rstn_i |=> !blk_req_o
  ) else begin
    err_cnt++;
    $error("blk_req_o high right after reset");
  end

endmodule

bind hash_regs_top hash_regs_chk u_hash_regs_chk (.*);

`default_nettype wire

// ==== source/hash_regs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hash_regs_top (
  input  wire                            clk_100mhz,
  input  wire                            rstn_i,
  // system bus slave
  input  wire hash_regs_pkg::bus_word_t  sys_addr_i,
  input  wire hash_regs_pkg::bus_word_t  sys_wdata_i,
  input  wire [3:0]                      sys_sel_i,
  input  wire                            sys_wen_i,
  input  wire                            sys_ren_i,
  output wire hash_regs_pkg::bus_word_t  sys_rdata_o,
  output wire                            sys_err_o,
  output wire                            sys_ack_o,
  // external sha-256 engine
  output wire                            blk_req_o,
  output wire hash_regs_pkg::block_t     blk_data_o,
  input  wire                            blk_ack_i,
  input  wire                            hash_valid_i,
  input  wire hash_regs_pkg::digest_t    hash_i,
  output wire                            active_o
);
  import hash_regs_pkg::*;

  logic    sha_en_w;          // domain enable
  block_t  fifo_block_w;
  logic    block_avail_w;
  logic    pop_w;
  digest_t hash_words_w;      // captured digest
  logic    hash_valid_w;
  logic    idle_w;

  word_push_if u_push ();     // pairs into the fifo

  sys_regfile u_sys_regfile (
    .clk_100mhz   (clk_100mhz),
    .rstn_i       (rstn_i),
    .sys_addr_i   (sys_addr_i),
    .sys_wdata_i  (sys_wdata_i),
    .sys_sel_i    (sys_sel_i),
    .sys_wen_i    (sys_wen_i),
    .sys_ren_i    (sys_ren_i),
    .sys_rdata_o  (sys_rdata_o),
    .sys_err_o    (sys_err_o),
    .sys_ack_o    (sys_ack_o),
    .push_w       (u_push.writer),
    .sha_en_o     (sha_en_w),
    .active_o     (active_o),
    .idle_i       (idle_w),
    .hash_valid_i (hash_valid_w),
    .hash_words_i (hash_words_w)
  );

  block_fifo u_block_fifo (
    .clk_100mhz    (clk_100mhz),
    .sha_en_i      (sha_en_w),
    .push_r        (u_push.reader),
    .block_o       (fifo_block_w),
    .block_avail_o (block_avail_w),
    .pop_i         (pop_w)
  );

  engine_link u_engine_link (
    .clk_100mhz    (clk_100mhz),
    .sha_en_i      (sha_en_w),
    .block_i       (fifo_block_w),
    .block_avail_i (block_avail_w),
    .pop_o         (pop_w),
    .blk_req_o     (blk_req_o),
    .blk_data_o    (blk_data_o),
    .blk_ack_i     (blk_ack_i),
    .hash_valid_i  (hash_valid_i),
    .hash_i        (hash_i),
    .hash_words_o  (hash_words_w),
    .hash_valid_o  (hash_valid_w),
    .idle_o        (idle_w)
  );

endmodule

`default_nettype wire

// ==== source/engine_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module engine_link (
  input  wire                           clk_100mhz,
  input  wire                           sha_en_i,       // low holds the link in reset
  // fifo side
  input  wire hash_regs_pkg::block_t    block_i,
  input  wire                           block_avail_i,
  output logic                          pop_o,
  // external sha-256 engine
  output logic                          blk_req_o,
  output hash_regs_pkg::block_t         blk_data_o,     // stable while blk_req_o
  input  wire                           blk_ack_i,
  input  wire                           hash_valid_i,
  input  wire hash_regs_pkg::digest_t   hash_i,
  // register file side
  output hash_regs_pkg::digest_t        hash_words_o,
  output logic                          hash_valid_o,   // sticky until domain reset
  output logic                          idle_o
);
  import hash_regs_pkg::*;

  typedef enum logic {
    LINK_IDLE,
    LINK_REQ
  } link_state_t;

  link_state_t state_q;
  logic        start_w;                                 // request about to rise
  logic        hash_valid_d;

  // new request only once the previous ack has gone low
  assign start_w = sha_en_i && (state_q == LINK_IDLE) && block_avail_i && !blk_ack_i;

  // --------------------------------------------------------------------------
  // four-phase requester
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!sha_en_i) begin
      state_q <= LINK_IDLE;
    end else begin
      case (state_q)
        LINK_IDLE: if (start_w)   state_q <= LINK_REQ;
        LINK_REQ:  if (blk_ack_i) state_q <= LINK_IDLE;  // req falls, block popped
        default:                  state_q <= LINK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (start_w) begin
      blk_data_o <= block_i;                            // frozen for the whole request
    end
  end

  assign blk_req_o = (state_q == LINK_REQ);
  assign pop_o     = (state_q == LINK_REQ) & blk_ack_i;
  assign idle_o    = (state_q == LINK_IDLE);

  // --------------------------------------------------------------------------
  // digest capture on the rising edge of hash_valid_i
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!sha_en_i) begin
      hash_valid_d <= 1'b0;
      hash_valid_o <= 1'b0;
      hash_words_o <= '0;
    end else begin
      hash_valid_d <= hash_valid_i;
      if (hash_valid_i && !hash_valid_d) begin
        hash_words_o <= hash_i;
        hash_valid_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/block_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hash_regs_config.svh"

module block_fifo (
  input  wire                    clk_100mhz,
  input  wire                    sha_en_i,        // low holds the fifo in reset
  word_push_if.reader            push_r,
  output hash_regs_pkg::block_t  block_o,         // oldest eight entries
  output logic                   block_avail_o,   // eight or more stored
  input  wire                    pop_i            // drop one block at once
);
  import hash_regs_pkg::*;

  localparam int DEPTH = `HR_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  pair_t         mem [DEPTH];                      // entry store
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;                         // stays on a block boundary
  logic [CW-1:0] count_q;
  logic          push_ok_w;
  logic          pop_ok_w;

  assign push_ok_w = push_r.push & ~push_r.full;   // full drops the push
  assign pop_ok_w  = pop_i & block_avail_o;

  always_ff @(posedge clk_100mhz) begin
    if (push_ok_w) begin
      mem[wr_ptr_q] <= push_r.pair;
    end
  end

  // --------------------------------------------------------------------------
  // pointers and fill count
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!sha_en_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok_w) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok_w) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 8)) ? '0 : rd_ptr_q + AW'(8);
      end
      count_q <= count_q + CW'(push_ok_w) - (pop_ok_w ? CW'(8) : CW'(0));
    end
  end

  // entry n of the block sits at bits 64n upward, no wrap inside a block
  always_comb begin
    for (int n = 0; n < 8; n++) begin
      block_o[64*n +: 64] = mem[rd_ptr_q + AW'(n)];
    end
  end

  // fill flags
  assign push_r.full        = (count_q == CW'(DEPTH));
  assign push_r.almost_full = (count_q >= CW'(DEPTH - 1));
  assign push_r.empty       = (count_q == '0);
  assign block_avail_o      = (count_q >= CW'(8));

endmodule

`default_nettype wire

// ==== source/sys_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hash_regs_config.svh"

module sys_regfile (
  input  wire                            clk_100mhz,
  input  wire                            rstn_i,        // sync, active low
  // system bus slave
  input  wire hash_regs_pkg::bus_word_t  sys_addr_i,
  input  wire hash_regs_pkg::bus_word_t  sys_wdata_i,
  input  wire [3:0]                      sys_sel_i,     // write byte lanes
  input  wire                            sys_wen_i,
  input  wire                            sys_ren_i,
  output hash_regs_pkg::bus_word_t       sys_rdata_o,
  output logic                           sys_err_o,
  output logic                           sys_ack_o,
  // towards the fifo
  word_push_if.writer                    push_w,
  // domain control and engine side status
  output logic                           sha_en_o,      // low holds fifo and link in reset
  output logic                           active_o,
  input  wire                            idle_i,
  input  wire                            hash_valid_i,
  input  wire hash_regs_pkg::digest_t    hash_words_i
);
  import hash_regs_pkg::*;

  localparam int CTRL_ENABLE    = 0;   // global enable
  localparam int SHA_CTRL_RESET = 0;   // one-shot sha reset

  logic [19:0] addr_w;                 // decode window
  logic [19:0] hash_off_w;             // distance from the first hash word
  bus_word_t   wmask_w;
  bus_word_t   wbits_w;                // write data, lanes applied
  logic        wr_ctrl_w;
  logic        wr_sha_ctrl_w;
  logic        wr_push_w;
  bus_word_t   ctrl_q;
  bus_word_t   sha_ctrl_q;
  bus_word_t   status_w;
  bus_word_t   sha_status_w;
  bus_word_t   rd_mux_w;
  logic        pair_hi_q;              // next push fills the high half
  logic        push_q;
  bus_word_t   pair_lo_q;
  pair_t       pair_q;

  // --------------------------------------------------------------------------
  // address decode
  // --------------------------------------------------------------------------
  assign addr_w     = sys_addr_i[19:0];
  assign hash_off_w = addr_w - `HR_ADDR_HASH_BASE;
  assign wmask_w    = {{8{sys_sel_i[3]}}, {8{sys_sel_i[2]}},
                       {8{sys_sel_i[1]}}, {8{sys_sel_i[0]}}};
  assign wbits_w    = sys_wdata_i & wmask_w;

  assign wr_ctrl_w     = sys_wen_i && (addr_w == `HR_ADDR_CTRL);
  assign wr_sha_ctrl_w = sys_wen_i && (addr_w == `HR_ADDR_SHA_CTRL);
  assign wr_push_w     = sys_wen_i && (addr_w == `HR_ADDR_SHA_PUSH);

  // --------------------------------------------------------------------------
  // control registers, pairing and domain enable
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      ctrl_q     <= '0;
      sha_ctrl_q <= '0;
      pair_hi_q  <= 1'b0;
      push_q     <= 1'b0;
      sys_ack_o  <= 1'b0;
      active_o   <= 1'b0;
      sha_en_o   <= 1'b0;
    end else begin
      sys_ack_o  <= sys_wen_i | sys_ren_i;             // one cycle after the request
      push_q     <= 1'b0;
      sha_ctrl_q <= sha_ctrl_q & ~`HR_ONESHOT_MASK;   // one-shots fall back
      if (wr_ctrl_w) begin
        ctrl_q <= (ctrl_q & ~wmask_w) | wbits_w;
      end
      if (wr_sha_ctrl_w) begin
        sha_ctrl_q <= (sha_ctrl_q & ~wmask_w) | wbits_w;
        if (wbits_w[SHA_CTRL_RESET]) begin
          pair_hi_q <= 1'b0;                           // restart pairing too
        end
      end
      if (wr_push_w) begin
        pair_hi_q <= ~pair_hi_q;
        push_q    <= pair_hi_q;                        // second word completes the entry
      end
      active_o <= ctrl_q[CTRL_ENABLE];
      sha_en_o <= ctrl_q[CTRL_ENABLE] & ~sha_ctrl_q[SHA_CTRL_RESET];
    end
  end

  // pair payload and read data
  always_ff @(posedge clk_100mhz) begin
    if (wr_push_w && !pair_hi_q) begin
      pair_lo_q <= sys_wdata_i;
    end
    if (wr_push_w && pair_hi_q) begin
      pair_q <= {sys_wdata_i, pair_lo_q};
    end
    sys_rdata_o <= sys_ren_i ? rd_mux_w : '0;
  end

  assign push_w.push = push_q;
  assign push_w.pair = pair_q;
  assign sys_err_o   = 1'b0;                           // bus never signals errors

  // --------------------------------------------------------------------------
  // status words and read mux
  // --------------------------------------------------------------------------
  always_comb begin
    status_w            = '0;
    status_w[ST_ACTIVE] = active_o;
    status_w[ST_SHA_EN] = sha_en_o;
  end

  always_comb begin
    sha_status_w                 = '0;
    sha_status_w[SS_IDLE]        = idle_i;
    sha_status_w[SS_HASH_VALID]  = hash_valid_i;
    sha_status_w[SS_EMPTY]       = push_w.empty;
    sha_status_w[SS_ALMOST_FULL] = push_w.almost_full;
    sha_status_w[SS_FULL]        = push_w.full;
  end

  always_comb begin
    rd_mux_w = '0;                                     // unmapped reads give zero
    case (addr_w)
      `HR_ADDR_CTRL:       rd_mux_w = ctrl_q;
      `HR_ADDR_STATUS:     rd_mux_w = status_w;
      `HR_ADDR_DATE:       rd_mux_w = `HR_BUILD_DATE;
      `HR_ADDR_SHA_CTRL:   rd_mux_w = sha_ctrl_q;
      `HR_ADDR_SHA_STATUS: rd_mux_w = sha_status_w;
      default: begin
        // eight hash words, word k holds digest bits 32k upward
        if (hash_off_w[19:5] == '0) begin
          rd_mux_w = hash_words_i[{hash_off_w[4:2], 5'd0} +: 32];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/word_push_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// 64 bit entries from the register file into the block fifo
interface word_push_if;
  import hash_regs_pkg::*;

  logic  push;         // one cycle strobe per entry
  pair_t pair;         // {second word, first word}
  logic  full;         // push is dropped while set
  logic  almost_full;
  logic  empty;

  modport writer (output push, output pair,
                  input  full, input almost_full, input empty);

  modport reader (input  push, input pair,
                  output full, output almost_full, output empty);

endinterface

`default_nettype wire

// ==== source/hash_regs_pkg.sv ====
`default_nettype none

package hash_regs_pkg;

  // --------------------------------------------------------------------------
  // payload types
  // --------------------------------------------------------------------------
  typedef logic [31:0]  bus_word_t;   // system bus word
  typedef logic [63:0]  pair_t;       // two pushed words, one fifo entry
  typedef logic [511:0] block_t;      // eight entries, one message block
  typedef logic [255:0] digest_t;     // sha-256 result

  // global status word
  localparam int ST_ACTIVE = 0;       // register block enabled
  localparam int ST_SHA_EN = 4;       // sha domain out of reset

  // sha-256 status word
  localparam int SS_IDLE        = 0;  // link waits for a block
  localparam int SS_HASH_VALID  = 1;  // digest captured
  localparam int SS_EMPTY       = 4;  // fifo holds nothing
  localparam int SS_ALMOST_FULL = 5;  // one free slot or less
  localparam int SS_FULL        = 6;  // further pushes are dropped

endpackage

`default_nettype wire

// ==== source/hash_regs_config.svh ====
`ifndef HASH_REGS_CONFIG_SVH
`define HASH_REGS_CONFIG_SVH

// --------------------------------------------------------------------------
// register map, byte offsets inside the 20 bit decode window
// --------------------------------------------------------------------------
`define HR_ADDR_CTRL        20'h00000  // global control, bit 0 enable
`define HR_ADDR_STATUS      20'h00004  // global status
`define HR_ADDR_DATE        20'h0000C  // build date word
`define HR_ADDR_SHA_CTRL    20'h00100  // sha-256 control, bit 0 reset
`define HR_ADDR_SHA_STATUS  20'h00104  // sha-256 status
`define HR_ADDR_SHA_PUSH    20'h0010C  // data push, two writes per entry
`define HR_ADDR_HASH_BASE   20'h00110  // eight hash words follow

// build stamp as 0xYYMMDDss, ss is the serial of that day
`define HR_BUILD_DATE       32'h16072801

// fifo capacity in 64 bit entries, keep it a multiple of 8
`define HR_FIFO_DEPTH       32

// sha control bits that clear themselves one cycle after the write
`define HR_ONESHOT_MASK     (32'h0000000F)

`endif
